// File: lm80c.f
src/lm80c_pkg.sv
src/lm80c_clock_enables.sv
src/lm80c_io_decoder.sv
src/lm80c_mem_arbiter.sv
src/lm80c_sysram.sv
src/lm80c_eraser.sv
src/lm80c_audio_dac.sv
src/lm80c_core.sv
verification/lm80c_asserts.sv
verification/lm80c_tb.sv

// File: Makefile
# Verilator flow for the LM80C board glue
VERILATOR ?= verilator
TOP       ?= lm80c_tb
RTL_TOP   ?= lm80c_core
FILELIST  ?= lm80c.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "No pass line in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/lm80c_tb.sv
// Testbench for lm80c_core that acts as CPU, peripherals and ROM downloader
// Immediate asserts here and bound concurrent asserts do the checking
`default_nettype none

module lm80c_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import lm80c_pkg::*;

	logic ram_clock = 1'b0;
	logic RESET = 1'b1;
	cpu_bus_t cpu_bus;
	periph_data_t periph;
	logic dl_valid, downloading, boot_done, reset_key, erase_trigger;
	logic [15:0] dl_addr;
	logic [7:0] dl_data, chan_a, chan_b, chan_c, got, mix_lo;
	io_sel_t io_sel, exp_sel, sel_got;
	logic [7:0] cpu_data;
	logic cpu_ena, psg_ena, sys_reset, cpu_wait, led, audio;
	logic [31:0] lcg_state = 32'h85f6_0cf1;
	logic [7:0] model [0:65535];
	logic [15:0] addr_q [$];
	logic [15:0] a;
	int i, n, ones, mix;

	lm80c_core UUT (
		.ram_clock(ram_clock), .RESET(RESET), .cpu_bus_i(cpu_bus), .periph_data_i(periph),
		.dl_valid_i(dl_valid), .dl_addr_i(dl_addr), .dl_data_i(dl_data),
		.downloading_i(downloading), .boot_done_i(boot_done), .reset_key_i(reset_key),
		.erase_trigger_i(erase_trigger), .chan_a_i(chan_a), .chan_b_i(chan_b),
		.chan_c_i(chan_c), .io_sel_o(io_sel), .cpu_data_o(cpu_data), .cpu_ena_o(cpu_ena),
		.psg_ena_o(psg_ena), .sys_reset_o(sys_reset), .cpu_wait_o(cpu_wait), .led_o(led),
		.audio_o(audio)
	);

	always #5 ram_clock = ~ram_clock;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic report_mismatch(input string what, input int value, input int expected);
		$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, value, expected);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// Hold one bus state for 6 cycles and sample after the fourth edge
	task automatic bus_cycle(input cpu_bus_t b);
		@(posedge ram_clock);
		#1 cpu_bus = b;
		repeat (4) @(posedge ram_clock);
		#1 got = cpu_data;
		sel_got = io_sel;
		repeat (2) @(posedge ram_clock);
		#1 cpu_bus = '0;
	endtask

	task automatic download(input logic [15:0] addr, input logic [7:0] data);
		@(posedge ram_clock);
		#1 dl_valid = 1'b1;
		dl_addr = addr;
		dl_data = data;
		model[addr] = data;
		@(posedge ram_clock);
		#1 dl_valid = 1'b0;
	endtask

	task automatic mem_check(input logic [15:0] addr);
		bus_cycle('{addr: addr, data: 8'h00, rd: 1'b1, wr: 1'b0, iorq: 1'b0, mreq: 1'b1,
			m1: 1'b0});
		assert (got == model[addr]) else report_mismatch("RAM byte", got, model[addr]);
	endtask

	// Expected select from the port's high nibble
	function automatic io_sel_t sel_for(input logic [3:0] nib);
		io_sel_t s;
		s = '0;
		case (nib)
			4'd0: s.pio = 1'b1;
			4'd1: s.ctc = 1'b1;
			4'd2: s.sio = 1'b1;
			4'd3: s.vdp = 1'b1;
			4'd4: s.psg = 1'b1;
			default: s = '0;
		endcase
		return s;
	endfunction

	// Poll the bound checker's error count
	always @(posedge ram_clock) begin
		if (UUT.u_asserts.error_count != 0) begin
			$display("Concurrent assertion failed at %0t ns", $time);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	initial begin
		cpu_bus = '0;
		periph = '0;
		dl_valid = 1'b0;
		dl_addr = 16'h0000;
		dl_data = 8'h00;
		downloading = 1'b0;
		boot_done = 1'b0;
		reset_key = 1'b0;
		erase_trigger = 1'b0;
		chan_a = 8'd0;
		chan_b = 8'd0;
		chan_c = 8'd0;
		for (i = 0; i < 65536; i++) model[i] = 8'h00;
		repeat (8) @(posedge ram_clock);
		#1 RESET = 1'b0;
		boot_done = 1'b1;

		// Let the enable checks see a few periods
		n = 0;
		for (i = 0; i < 100 && n < 3; i++) begin
			@(posedge ram_clock);
			#1 if (psg_ena) n++;
		end
		if (n < 3) report_timeout("sound chip enable pulses");

		// Port reads by nibble, then interrupt acknowledge
		for (i = 0; i < 5; i++) begin
			periph = periph_data_t'(lcg_next());
			a = {8'h00, 4'(i), 4'(lcg_next())};
			bus_cycle('{addr: a, data: 8'h00, rd: 1'b1, wr: 1'b0, iorq: 1'b1, mreq: 1'b0,
				m1: 1'b0});
			exp_sel = sel_for(4'(i));
			assert (sel_got == exp_sel) else report_mismatch("chip select", sel_got, exp_sel);
			case (i)
				1: assert (got == periph.ctc) else report_mismatch("CTC read", got, periph.ctc);
				3: assert (got == periph.vdp) else report_mismatch("VDP read", got, periph.vdp);
				4: assert (got == periph.psg) else report_mismatch("PSG read", got, periph.psg);
				default: assert (got == 8'h00) else report_mismatch("empty port", got, 0);
			endcase
		end
		periph = periph_data_t'(lcg_next());
		bus_cycle('{addr: 16'h0010, data: 8'h00, rd: 1'b0, wr: 1'b0, iorq: 1'b1, mreq: 1'b0,
			m1: 1'b1});
		assert (sel_got == sel_for(4'd1)) else report_mismatch("INTA select", sel_got, 6'h10);
		assert (got == periph.ctc) else report_mismatch("INTA vector", got, periph.ctc);

		// LED port written nonzero then zero
		mix_lo = 8'(lcg_next()) | 8'h01;
		bus_cycle('{addr: 16'h00FF, data: mix_lo, rd: 1'b0, wr: 1'b1, iorq: 1'b1, mreq: 1'b0,
			m1: 1'b0});
		assert (led) else report_mismatch("LED", led, 1);
		bus_cycle('{addr: 16'h00FF, data: 8'h00, rd: 1'b1, wr: 1'b0, iorq: 1'b1, mreq: 1'b0,
			m1: 1'b0});
		assert (got == mix_lo) else report_mismatch("LED readback", got, mix_lo);
		bus_cycle('{addr: 16'h00FF, data: 8'h00, rd: 1'b0, wr: 1'b1, iorq: 1'b1, mreq: 1'b0,
			m1: 1'b0});
		assert (!led) else report_mismatch("LED", led, 0);

		// Reset key alone raises system reset
		@(posedge ram_clock);
		#1 reset_key = 1'b1;
		@(posedge ram_clock);
		#1 assert (sys_reset) else report_mismatch("system reset", sys_reset, 1);
		reset_key = 1'b0;

		// ROM area and RAM window downloads with the CPU held in wait
		downloading = 1'b1;
		for (i = 0; i < 32; i++) begin
			a = (i < 16) ? 16'(lcg_next()) & 16'h7FFF : 16'h8000 | (16'(lcg_next()) & 16'h3FFF);
			addr_q.push_back(a);
			download(a, 8'(lcg_next()));
		end
		assert (cpu_wait) else report_mismatch("CPU wait", cpu_wait, 1);
		downloading = 1'b0;
		foreach (addr_q[k]) mem_check(addr_q[k]);
		// ROM stays write protected for the CPU
		bus_cycle('{addr: addr_q[0], data: ~model[addr_q[0]], rd: 1'b0, wr: 1'b1, iorq: 1'b0,
			mreq: 1'b1, m1: 1'b0});
		mem_check(addr_q[0]);
		a = addr_q[20];
		model[a] = 8'(lcg_next());
		bus_cycle('{addr: a, data: model[a], rd: 1'b0, wr: 1'b1, iorq: 1'b0, mreq: 1'b1,
			m1: 1'b0});
		mem_check(a);

		// Erase sweep with downloads stealing cycles
		assert (!sys_reset && !cpu_wait)
			else report_mismatch("reset and wait", {sys_reset, cpu_wait}, 0);
		@(posedge ram_clock);
		#1 erase_trigger = 1'b1;
		@(posedge ram_clock);
		#1 erase_trigger = 1'b0;
		for (i = 0; i < 4 && !sys_reset; i++) begin
			@(posedge ram_clock);
			#1;
		end
		if (!sys_reset) report_timeout("erase start");
		assert (cpu_wait) else report_mismatch("CPU wait", cpu_wait, 1);
		for (i = 0; i < 40000 && sys_reset; i++) begin
			@(posedge ram_clock);
			#1 dl_valid = (i % 5 == 0) && sys_reset;
			if (dl_valid) begin
				dl_addr = 16'(lcg_next()) & 16'h7FFF;
				dl_data = 8'(lcg_next());
				model[dl_addr] = dl_data;
				addr_q.push_back(dl_addr);
			end
		end
		dl_valid = 1'b0;
		if (sys_reset) report_timeout("erase end");
		assert (!cpu_wait) else report_mismatch("CPU wait", cpu_wait, 0);
		for (i = RAM_FIRST; i <= RAM_LAST; i++) model[i] = ERASE_FILL;
		for (i = RAM_FIRST; i <= RAM_LAST; i++) mem_check(16'(i));
		foreach (addr_q[k]) mem_check(addr_q[k]);

		// Ones over 1024 cycles expected near mix*64*1024/65536 = mix
		for (n = 0; n < 4; n++) begin
			chan_a = 8'(lcg_next());
			chan_b = 8'(lcg_next());
			chan_c = 8'(lcg_next());
			mix = chan_a + chan_b + chan_c;
			repeat (2) @(posedge ram_clock);
			ones = 0;
			for (i = 0; i < 1024; i++) begin
				@(posedge ram_clock);
				#1 ones += audio;
			end
			assert (ones >= mix - 1 && ones <= mix + 1) else report_mismatch("audio ones", ones, mix);
		end
		chan_a = 8'd0;
		chan_b = 8'd0;
		chan_c = 8'd0;
		repeat (64) @(posedge ram_clock);

		if (UUT.u_asserts.error_count == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("** FAIL **");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: verification/lm80c_asserts.sv
// Concurrent checks on the lm80c_core ports
// Bound into lm80c_core to watch enables, selects, LED, erase entry, audio and reset
`default_nettype none

module lm80c_asserts (
	input wire                          ram_clock,
	input wire                          RESET,
	input wire lm80c_pkg::cpu_bus_t     cpu_bus_i,
	input wire                          erase_trigger_i,
	input wire [7:0]                    chan_a_i,
	input wire [7:0]                    chan_b_i,
	input wire [7:0]                    chan_c_i,
	input wire lm80c_pkg::io_sel_t      io_sel_o,
	input wire                          cpu_ena_o,
	input wire                          psg_ena_o,
	input wire                          sys_reset_o,
	input wire                          cpu_wait_o,
	input wire                          led_o,
	input wire                          audio_o
);
	timeunit 1ns;
	timeprecision 100ps;

	int         error_count = 0;
	logic [3:0] cpu_gap;
	logic [3:0] psg_gap;
	logic       cpu_seen;
	logic       psg_seen;

	// Saturating count of cycles since the previous enable pulse
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_gap  <= 4'd0;
			psg_gap  <= 4'd0;
			cpu_seen <= 1'b0;
			psg_seen <= 1'b0;
		end else begin
			if (cpu_ena_o) begin
				cpu_gap  <= 4'd1;
				cpu_seen <= 1'b1;
			end else if (cpu_gap != 4'hF) begin
				cpu_gap <= cpu_gap + 4'd1;
			end
			if (psg_ena_o) begin
				psg_gap  <= 4'd1;
				psg_seen <= 1'b1;
			end else if (psg_gap != 4'hF) begin
				psg_gap <= psg_gap + 4'd1;
			end
		end
	end

	// CPU enable alternates gaps of 5 and 6
	cpu_gap_a: assert property (@(posedge ram_clock) disable iff (RESET)
		cpu_ena_o && cpu_seen |-> (cpu_gap == 4'd5) || (cpu_gap == 4'd6))
		else begin $error("cpu enable gap wrong"); error_count++; end

	psg_gap_a: assert property (@(posedge ram_clock) disable iff (RESET)
		psg_ena_o && psg_seen |-> psg_gap == 4'd11)
		else begin $error("psg enable period wrong"); error_count++; end

	psg_on_cpu_a: assert property (@(posedge ram_clock) disable iff (RESET)
		psg_ena_o |-> cpu_ena_o)
		else begin $error("psg enable off the cpu phase"); error_count++; end

	// At most one chip select and none outside I/O cycles
	sel_onehot_a: assert property (@(posedge ram_clock) disable iff (RESET)
		$onehot0(io_sel_o))
		else begin $error("several chip selects"); error_count++; end

	sel_idle_a: assert property (@(posedge ram_clock) disable iff (RESET)
		!$past(cpu_bus_i.iorq) |-> io_sel_o == '0)
		else begin $error("select without iorq"); error_count++; end

	// LED follows the written byte
	led_a: assert property (@(posedge ram_clock) disable iff (RESET)
		$past(io_sel_o.led && cpu_bus_i.wr) |-> led_o == ($past(cpu_bus_i.data) != 8'h00))
		else begin $error("led state wrong"); error_count++; end

	erase_a: assert property (@(posedge ram_clock) disable iff (RESET)
		$past(erase_trigger_i) && !$past(erase_trigger_i, 2) |-> sys_reset_o && cpu_wait_o)
		else begin $error("no reset and wait on erase"); error_count++; end

	// Silent input gives no carry
	audio_zero_a: assert property (@(posedge ram_clock) disable iff (RESET)
		$past(chan_a_i == 8'd0 && chan_b_i == 8'd0 && chan_c_i == 8'd0) |-> !audio_o)
		else begin $error("audio toggles on silence"); error_count++; end

	reset_a: assert property (@(posedge ram_clock)
		$fell(RESET) |-> io_sel_o == '0 && !led_o && !audio_o && !sys_reset_o)
		else begin $error("outputs not cleared by reset"); error_count++; end

endmodule

bind lm80c_core lm80c_asserts u_asserts (
	.ram_clock       (ram_clock),
	.RESET           (RESET),
	.cpu_bus_i       (cpu_bus_i),
	.erase_trigger_i (erase_trigger_i),
	.chan_a_i        (chan_a_i),
	.chan_b_i        (chan_b_i),
	.chan_c_i        (chan_c_i),
	.io_sel_o        (io_sel_o),
	.cpu_ena_o       (cpu_ena_o),
	.psg_ena_o       (psg_ena_o),
	.sys_reset_o     (sys_reset_o),
	.cpu_wait_o      (cpu_wait_o),
	.led_o           (led_o),
	.audio_o         (audio_o)
);

`default_nettype wire

// File: src/lm80c_core.sv
// LM80C board glue top level
// CPU, VDP, PSG and CTC live outside and connect through these ports
// Holds the RAM path, I/O decode, eraser, audio DAC and reset/wait logic
`default_nettype none

module lm80c_core (
	input  wire                          ram_clock,
	input  wire                          RESET,
	input  wire lm80c_pkg::cpu_bus_t     cpu_bus_i,
	input  wire lm80c_pkg::periph_data_t periph_data_i,
	input  wire                          dl_valid_i,
	input  wire [15:0]                   dl_addr_i,
	input  wire [7:0]                    dl_data_i,
	input  wire                          downloading_i,
	input  wire                          boot_done_i,
	input  wire                          reset_key_i,
	input  wire                          erase_trigger_i,
	input  wire [7:0]                    chan_a_i,
	input  wire [7:0]                    chan_b_i,
	input  wire [7:0]                    chan_c_i,
	output lm80c_pkg::io_sel_t           io_sel_o,
	output logic [7:0]                   cpu_data_o,
	output logic                         cpu_ena_o,
	output logic                         psg_ena_o,
	output logic                         sys_reset_o,
	output logic                         cpu_wait_o,
	output logic                         led_o,
	output logic                         audio_o
);
	import lm80c_pkg::*;

	mem_req_t   erase_req;
	mem_req_t   ram_req;
	logic       erase_valid;
	logic       erase_ready;
	logic       erase_busy;
	logic [7:0] ram_data;

	// CPU and PSG enables
	lm80c_clock_enables u_clock_enables (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.cpu_ena_o (cpu_ena_o),
		.psg_ena_o (psg_ena_o)
	);

	lm80c_io_decoder u_io_decoder (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.bus_i         (cpu_bus_i),
		.periph_data_i (periph_data_i),
		.ram_data_i    (ram_data),
		.io_sel_o      (io_sel_o),
		.cpu_data_o    (cpu_data_o),
		.led_o         (led_o)
	);

	// Sweeps the RAM window on request
	lm80c_eraser u_eraser (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.trigger_i   (erase_trigger_i),
		.busy_o      (erase_busy),
		.req_valid_o (erase_valid),
		.req_o       (erase_req),
		.req_ready_i (erase_ready)
	);

	lm80c_mem_arbiter u_mem_arbiter (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.bus_i         (cpu_bus_i),
		.dl_valid_i    (dl_valid_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.erase_valid_i (erase_valid),
		.erase_req_i   (erase_req),
		.erase_ready_o (erase_ready),
		.mem_req_o     (ram_req)
	);

	lm80c_sysram u_sysram (
		.ram_clock (ram_clock),
		.req_i     (ram_req),
		.data_o    (ram_data)
	);

	lm80c_audio_dac u_audio_dac (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.chan_a_i  (chan_a_i),
		.chan_b_i  (chan_b_i),
		.chan_c_i  (chan_c_i),
		.audio_o   (audio_o)
	);

	// System reset for CPU and peripherals while booting, on the key or erasing
	assign sys_reset_o = ~boot_done_i | reset_key_i | erase_busy;
	// CPU stalls whenever something else owns the RAM for long
	assign cpu_wait_o  = ~boot_done_i | downloading_i | erase_busy;

endmodule

`default_nettype wire

// File: src/lm80c_audio_dac.sv
// Audio mixer and one bit sigma-delta DAC
// Sums the three sound channels and outputs the accumulator carry
`default_nettype none

module lm80c_audio_dac (
	input  wire       ram_clock,
	input  wire       RESET,
	input  wire [7:0] chan_a_i,
	input  wire [7:0] chan_b_i,
	input  wire [7:0] chan_c_i,
	output logic      audio_o
);
	import lm80c_pkg::*;

	logic [9:0]           mix_sum;
	logic [DAC_WIDTH-1:0] dac_in;
	logic [DAC_WIDTH-1:0] acc;
	logic [DAC_WIDTH:0]   acc_next;

	// Three 8-bit channels fit in 10 bits
	assign mix_sum = 10'(chan_a_i) + 10'(chan_b_i) + 10'(chan_c_i);
	// Scale up to full DAC width
	assign dac_in  = DAC_WIDTH'(mix_sum) << MIX_SHIFT;

	// First order sum with the carry on top
	assign acc_next = {1'b0, acc} + {1'b0, dac_in};

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			acc     <= '0;
			audio_o <= 1'b0;
		end else begin
			acc     <= acc_next[DAC_WIDTH-1:0];
			// Carry density tracks the input level
			audio_o <= acc_next[DAC_WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: src/lm80c_eraser.sv
// Clears the RAM window after a trigger edge
// Issues one fill write per accepted transfer, busy while sweeping
`default_nettype none

module lm80c_eraser (
	input  wire                 ram_clock,
	input  wire                 RESET,
	input  wire                 trigger_i,
	output logic                busy_o,
	output logic                req_valid_o,
	output lm80c_pkg::mem_req_t req_o,
	input  wire                 req_ready_i
);
	import lm80c_pkg::*;

	erase_state_e state;
	logic         trigger_q;
	logic [15:0]  addr;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			state     <= ERASE_IDLE;
			trigger_q <= 1'b0;
		end else begin
			trigger_q <= trigger_i;
			case (state)
				ERASE_IDLE: begin
					// Rising edge starts a sweep
					if (trigger_i && !trigger_q) begin
						state <= ERASE_RUN;
					end
				end
				ERASE_RUN: begin
					if (req_ready_i && addr == RAM_LAST) begin
						state <= ERASE_IDLE;
					end
				end
				default: state <= ERASE_IDLE;
			endcase
		end
	end

	// Address reloads while idle, steps only on accepted writes
	always_ff @(posedge ram_clock) begin
		if (state == ERASE_IDLE) begin
			addr <= RAM_FIRST;
		end else if (req_ready_i) begin
			addr <= addr + 16'd1;
		end
	end

	assign busy_o      = (state == ERASE_RUN);
	assign req_valid_o = busy_o;
	assign req_o       = '{addr: addr, data: ERASE_FILL, we: 1'b1};

endmodule

`default_nettype wire

// File: src/lm80c_sysram.sv
// 64 KiB system RAM, one port
// Write on the strobe, registered read of the same address
`default_nettype none

module lm80c_sysram (
	input  wire                     ram_clock,
	input  wire lm80c_pkg::mem_req_t req_i,
	output logic [7:0]              data_o
);

	logic [7:0] mem [0:65535];

	always_ff @(posedge ram_clock) begin
		if (req_i.we) begin
			mem[req_i.addr] <= req_i.data;
		end
		// Read returns the old byte on a write cycle
		data_o <= mem[req_i.addr];
	end

endmodule

`default_nettype wire

// File: src/lm80c_mem_arbiter.sv
// RAM access arbiter
// Fixed priority: ROM download, then eraser, then CPU
// Winning request is registered toward the system RAM
`default_nettype none

module lm80c_mem_arbiter (
	input  wire                     ram_clock,
	input  wire                     RESET,
	input  wire lm80c_pkg::cpu_bus_t bus_i,
	input  wire                     dl_valid_i,
	input  wire [15:0]              dl_addr_i,
	input  wire [7:0]               dl_data_i,
	input  wire                     erase_valid_i,
	input  wire lm80c_pkg::mem_req_t erase_req_i,
	output logic                    erase_ready_o,
	output lm80c_pkg::mem_req_t     mem_req_o
);
	import lm80c_pkg::*;

	mem_req_t    req_next;
	logic        cpu_in_window;
	logic [15:0] addr_q;
	logic [7:0]  data_q;
	logic        we_q;

	// Download never waits, eraser stalls behind it
	assign erase_ready_o = ~dl_valid_i;

	// ROM area is write protected for the CPU
	assign cpu_in_window = (bus_i.addr >= RAM_FIRST) && (bus_i.addr <= RAM_LAST);

	always_comb begin
		if (dl_valid_i) begin
			req_next = '{addr: dl_addr_i, data: dl_data_i, we: 1'b1};
		end else if (erase_valid_i) begin
			req_next = erase_req_i;
		end else begin
			req_next.addr = bus_i.addr;
			req_next.data = bus_i.data;
			req_next.we   = bus_i.mreq & bus_i.wr & cpu_in_window;
		end
	end

	// Address and data
	always_ff @(posedge ram_clock) begin
		addr_q <= req_next.addr;
		data_q <= req_next.data;
	end

	// Write strobe, cleared in reset
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			we_q <= 1'b0;
		end else begin
			we_q <= req_next.we;
		end
	end

	assign mem_req_o = '{addr: addr_q, data: data_q, we: we_q};

endmodule

`default_nettype wire

// File: src/lm80c_io_decoder.sv
// I/O address decoder for the CPU side of the board
// Registers chip selects one cycle after the bus, then the read byte
// Also holds the LED latch on port 0xFF
`default_nettype none

module lm80c_io_decoder (
	input  wire                     ram_clock,
	input  wire                     RESET,
	input  wire lm80c_pkg::cpu_bus_t     bus_i,
	input  wire lm80c_pkg::periph_data_t periph_data_i,
	input  wire [7:0]               ram_data_i,
	output lm80c_pkg::io_sel_t      io_sel_o,
	output logic [7:0]              cpu_data_o,
	output logic                    led_o
);
	import lm80c_pkg::*;

	logic       is_io;
	logic [3:0] port_hi;
	logic [7:0] led_latch;
	logic [7:0] rd_byte;

	// Pure I/O cycle, memory cycles never select a port
	assign is_io   = bus_i.iorq & ~bus_i.mreq;
	assign port_hi = bus_i.addr[7:4];

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			io_sel_o <= '0;
		end else begin
			io_sel_o.pio <= is_io && (port_hi == IO_PIO);
			io_sel_o.ctc <= is_io && (port_hi == IO_CTC);
			io_sel_o.sio <= is_io && (port_hi == IO_SIO);
			io_sel_o.vdp <= is_io && (port_hi == IO_VDP);
			io_sel_o.psg <= is_io && (port_hi == IO_PSG);
			// Debug LED port, full byte compare
			io_sel_o.led <= is_io && (bus_i.addr[7:0] == LED_PORT);
		end
	end

	// LED latch written through the registered select
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			led_latch <= 8'h00;
		end else if (io_sel_o.led && bus_i.wr) begin
			led_latch <= bus_i.data;
		end
	end

	assign led_o = (led_latch != 8'h00);

	// Read source by select, RAM when no port is selected
	always_comb begin
		if (io_sel_o.pio) begin
			rd_byte = 8'h00;
		end else if (io_sel_o.ctc) begin
			rd_byte = periph_data_i.ctc;
		end else if (io_sel_o.sio) begin
			rd_byte = 8'h00;
		end else if (io_sel_o.vdp) begin
			rd_byte = periph_data_i.vdp;
		end else if (io_sel_o.psg) begin
			rd_byte = periph_data_i.psg;
		end else if (io_sel_o.led) begin
			rd_byte = led_latch;
		end else begin
			rd_byte = ram_data_i;
		end
	end

	always_ff @(posedge ram_clock) begin
		if (bus_i.rd) begin
			cpu_data_o <= rd_byte;
		end else if (bus_i.iorq && bus_i.m1) begin
			// Interrupt acknowledge, CTC supplies the vector
			cpu_data_o <= periph_data_i.ctc;
		end
		// Otherwise hold the last byte
	end

endmodule

`default_nettype wire

// File: src/lm80c_clock_enables.sv
// CPU and sound chip clock enables from the fast RAM clock
// Counts 0 to 10, CPU enabled at 0 and 5, sound chip at 0
`default_nettype none

module lm80c_clock_enables (
	input  wire  ram_clock,
	input  wire  RESET,
	output logic cpu_ena_o,
	output logic psg_ena_o
);
	import lm80c_pkg::*;

	logic [3:0] cnt;
	logic [3:0] cnt_next;

	// Wrap after the last count
	assign cnt_next = (cnt == CLK_DIV_LAST) ? 4'd0 : cnt + 4'd1;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			// First count after reset is 0
			cnt       <= CLK_DIV_LAST;
			cpu_ena_o <= 1'b0;
			psg_ena_o <= 1'b0;
		end else begin
			cnt       <= cnt_next;
			// Enables line up with the count they decode
			cpu_ena_o <= (cnt_next == 4'd0) || (cnt_next == 4'd5);
			psg_ena_o <= (cnt_next == 4'd0);
		end
	end

endmodule

`default_nettype wire

// File: src/lm80c_pkg.sv
// Shared types and constants for the LM80C board glue
// Bus, select and memory request structs, port codes and address map
// Modules use the types by scoped name in ports, wildcard import inside
`default_nettype none

package lm80c_pkg;

	// One CPU bus state, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rd;
		logic        wr;
		logic        iorq;
		logic        mreq;
		logic        m1;
	} cpu_bus_t;

	// Registered I/O chip selects
	typedef struct packed {
		logic pio;
		logic ctc;
		logic sio;
		logic vdp;
		logic psg;
		logic led;
	} io_sel_t;

	// Read bytes returned by the peripherals
	typedef struct packed {
		logic [7:0] ctc;
		logic [7:0] vdp;
		logic [7:0] psg;
	} periph_data_t;

	// Single RAM access, read always, write when we is set
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        we;
	} mem_req_t;

	// High nibble of the I/O port address
	typedef enum logic [3:0] {
		IO_PIO = 4'd0,
		IO_CTC = 4'd1,
		IO_SIO = 4'd2,
		IO_VDP = 4'd3,
		IO_PSG = 4'd4
	} io_port_e;

	typedef enum logic {
		ERASE_IDLE = 1'b0,
		ERASE_RUN  = 1'b1
	} erase_state_e;

	// Divide by eleven
	localparam logic [3:0]  CLK_DIV_LAST = 4'd10;
	localparam logic [7:0]  LED_PORT     = 8'hFF;
	// Writable RAM window, everything below is ROM
	localparam logic [15:0] RAM_FIRST    = 16'h8000;
	localparam logic [15:0] RAM_LAST     = 16'hBFFF;
	localparam logic [7:0]  ERASE_FILL   = 8'h00;
	localparam int          DAC_WIDTH    = 16;
	localparam int          MIX_SHIFT    = 6;

endpackage

`default_nettype wire
